//--- fetch_frontend.f
+incdir+hw
hw/isa_pkg.sv
hw/mem_pkg.sv
hw/icache.sv
hw/branch_predecode.sv
hw/ifu.sv
hw/fetch_frontend.sv
verification/fetch_frontend_sva.sv
verification/fetch_frontend_tb.sv

//--- hw/branch_predecode.sv
module branch_predecode (
  input  mem_pkg::word_addr_t fetch_pc,
  input  logic [31:0]         inst,
  output mem_pkg::word_addr_t pred_pc
);

  isa_pkg::inst_word_u word;

  logic        is_branch;
  logic        is_jal;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] pc_incr;

  assign word.raw = inst;

  assign is_branch = word.b_fields.opcode == isa_pkg::OPC_BRANCH;
  assign is_jal    = word.j_fields.opcode == isa_pkg::OPC_JAL;

  // sign-extended offsets, bit 0 is always zero
  assign imm_b = {{20{word.b_fields.imm12}}, word.b_fields.imm11, word.b_fields.imm10_5,
                  word.b_fields.imm4_1, 1'b0};
  assign imm_j = {{12{word.j_fields.imm20}}, word.j_fields.imm19_12, word.j_fields.imm11,
                  word.j_fields.imm10_1, 1'b0};

  // static rule: backward branches and jal are taken
  always_comb begin
    if (is_jal) begin
      pc_incr = imm_j;
    end else if (is_branch && word.b_fields.imm12) begin
      pc_incr = imm_b;
    end else begin
      pc_incr = 32'd4;
    end
  end

  assign pred_pc = fetch_pc + pc_incr;

endmodule

//--- hw/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// **************************************************
// fetch front end configuration
// **************************************************

// first fetch address after reset, one word
`define FETCH_RESET_PC 32'h8000_0000

// cache geometry, both must be powers of two
// line words must be at least two
`define ICACHE_LINES 16
`define ICACHE_LINE_WORDS 4

// word reads that may be in flight toward memory
`define MEM_CREDITS 2

`endif

//--- hw/fetch_frontend.sv
module fetch_frontend (
  input  logic                clock,
  input  logic                reset,

  input  logic                fencei,
  input  logic                jump_flush,
  input  mem_pkg::word_addr_t jump_dnpc,
  input  logic                cs_flush,
  input  mem_pkg::word_addr_t cs_dnpc,

  output logic                mem_req_valid,
  output mem_pkg::word_addr_t mem_req_addr,
  input  logic                mem_credit,
  input  logic                mem_resp_valid,
  input  logic [31:0]         mem_resp_data,

  input  logic                out_ready,
  output logic                out_valid,
  output mem_pkg::word_addr_t out_pc,
  output logic [31:0]         out_inst
);

  mem_pkg::word_addr_t fetch_pc;
  mem_pkg::word_addr_t pred_pc;
  logic                hit;
  logic [31:0]         inst;

  icache u_icache (
    .clock          (clock),
    .reset          (reset),
    .fencei         (fencei),
    .fetch_pc       (fetch_pc),
    .hit            (hit),
    .inst           (inst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_credit     (mem_credit),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

  branch_predecode u_predecode (
    .fetch_pc (fetch_pc),
    .inst     (inst),
    .pred_pc  (pred_pc)
  );

  ifu u_ifu (
    .clock      (clock),
    .reset      (reset),
    .hit        (hit),
    .inst       (inst),
    .pred_pc    (pred_pc),
    .fetch_pc   (fetch_pc),
    .jump_flush (jump_flush),
    .jump_dnpc  (jump_dnpc),
    .cs_flush   (cs_flush),
    .cs_dnpc    (cs_dnpc),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_inst   (out_inst)
  );

endmodule

//--- hw/icache.sv
`include "fetch_cfg.svh"

module icache (
  input  logic                clock,
  input  logic                reset,
  input  logic                fencei,
  input  mem_pkg::word_addr_t fetch_pc,
  output logic                hit,
  output logic [31:0]         inst,
  output logic                mem_req_valid,
  output mem_pkg::word_addr_t mem_req_addr,
  input  logic                mem_credit,
  input  logic                mem_resp_valid,
  input  logic [31:0]         mem_resp_data
);

  localparam int LINES      = `ICACHE_LINES;
  localparam int LINE_WORDS = `ICACHE_LINE_WORDS;

  // **************************************************
  // arrays and lookup
  // **************************************************

  logic [LINES-1:0] valid_q;
  mem_pkg::tag_t    tag_q  [LINES];
  logic [31:0]      data_q [LINES][LINE_WORDS];

  mem_pkg::tag_t        pc_tag;
  mem_pkg::line_index_t pc_idx;
  mem_pkg::word_off_t   pc_off;

  assign {pc_tag, pc_idx, pc_off} = fetch_pc[31:2];

  assign hit  = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign inst = data_q[pc_idx][pc_off];

  // **************************************************
  // refill engine
  // **************************************************

  logic                 busy_q;
  logic                 fence_pend_q;
  mem_pkg::line_index_t fill_idx_q;
  mem_pkg::tag_t        fill_tag_q;
  mem_pkg::fill_cnt_t   issued_q;
  mem_pkg::fill_cnt_t   outst_q;
  mem_pkg::credit_t     credits_q;

  logic               start_fill;
  logic               resp_fire;
  logic               last_word;
  mem_pkg::fill_cnt_t fill_word;

  // fetch_pc does not move while it misses, so a refill always serves it
  assign start_fill = !busy_q && !hit;
  assign resp_fire  = busy_q && mem_resp_valid;

  assign mem_req_valid = busy_q && (issued_q != mem_pkg::fill_cnt_t'(LINE_WORDS)) &&
                         (credits_q != '0);
  assign mem_req_addr  = {fill_tag_q, fill_idx_q, issued_q[mem_pkg::WORD_OFF_W-1:0], 2'b00};

  // responses return in request order, so the word being written is
  // the oldest one still outstanding
  assign fill_word = issued_q - outst_q;
  assign last_word = fill_word == mem_pkg::fill_cnt_t'(LINE_WORDS - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q      <= '0;
      busy_q       <= 1'b0;
      fence_pend_q <= 1'b0;
      issued_q     <= '0;
      outst_q      <= '0;
      credits_q    <= mem_pkg::credit_t'(`MEM_CREDITS);
    end else begin
      credits_q <= credits_q - mem_pkg::credit_t'(mem_req_valid) +
                   mem_pkg::credit_t'(mem_credit);
      outst_q   <= outst_q + mem_pkg::fill_cnt_t'(mem_req_valid) -
                   mem_pkg::fill_cnt_t'(resp_fire);

      if (start_fill) begin
        busy_q          <= 1'b1;
        fence_pend_q    <= 1'b0;
        issued_q        <= '0;
        valid_q[pc_idx] <= 1'b0;
      end else if (busy_q) begin
        if (mem_req_valid) begin
          issued_q <= issued_q + mem_pkg::fill_cnt_t'(1);
        end
        if (fencei) begin
          fence_pend_q <= 1'b1;
        end
        if (resp_fire && last_word) begin
          busy_q <= 1'b0;
          // a fence.i seen during the refill leaves the line invalid
          if (!fence_pend_q) begin
            valid_q[fill_idx_q] <= 1'b1;
          end
        end
      end

      if (fencei) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_fill) begin
      fill_idx_q    <= pc_idx;
      fill_tag_q    <= pc_tag;
      tag_q[pc_idx] <= pc_tag;
    end
    if (resp_fire) begin
      data_q[fill_idx_q][fill_word[mem_pkg::WORD_OFF_W-1:0]] <= mem_resp_data;
    end
  end

endmodule

//--- hw/ifu.sv
`include "fetch_cfg.svh"

module ifu (
  input  logic                clock,
  input  logic                reset,
  input  logic                hit,
  input  logic [31:0]         inst,
  input  mem_pkg::word_addr_t pred_pc,
  output mem_pkg::word_addr_t fetch_pc,
  input  logic                jump_flush,
  input  mem_pkg::word_addr_t jump_dnpc,
  input  logic                cs_flush,
  input  mem_pkg::word_addr_t cs_dnpc,
  input  logic                out_ready,
  output logic                out_valid,
  output mem_pkg::word_addr_t out_pc,
  output logic [31:0]         out_inst
);

  logic                out_valid_q;
  logic                out_valid_d;
  mem_pkg::word_addr_t out_pc_d;
  logic [31:0]         out_inst_d;
  mem_pkg::word_addr_t fetch_pc_d;
  logic                pend_q;
  logic                pend_d;
  mem_pkg::word_addr_t pend_pc_q;
  mem_pkg::word_addr_t pend_pc_d;

  logic                flush;
  mem_pkg::word_addr_t flush_pc;

  // control-status redirects win over jumps
  assign flush    = jump_flush | cs_flush;
  assign flush_pc = cs_flush ? cs_dnpc : jump_dnpc;

  // **************************************************
  // next-state logic
  // **************************************************

  always_comb begin
    out_valid_d = out_valid_q;
    out_pc_d    = out_pc;
    out_inst_d  = out_inst;
    fetch_pc_d  = fetch_pc;
    pend_d      = pend_q;
    pend_pc_d   = pend_pc_q;

    if (flush) begin
      // the held instruction is on the wrong path
      out_valid_d = 1'b0;
      pend_d      = 1'b1;
      pend_pc_d   = flush_pc;
    end else if (pend_q) begin
      // hit means no refill is in progress for the old fetch_pc
      if (hit) begin
        pend_d     = 1'b0;
        fetch_pc_d = pend_pc_q;
      end
    end else if (!out_valid_q || out_ready) begin
      if (hit) begin
        out_valid_d = 1'b1;
        out_pc_d    = fetch_pc;
        out_inst_d  = inst;
        fetch_pc_d  = pred_pc;
      end else begin
        out_valid_d = 1'b0;
      end
    end
  end

  // **************************************************
  // registers
  // **************************************************

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_q <= 1'b0;
      pend_q      <= 1'b0;
      fetch_pc    <= `FETCH_RESET_PC;
    end else begin
      out_valid_q <= out_valid_d;
      pend_q      <= pend_d;
      fetch_pc    <= fetch_pc_d;
    end
  end

  always_ff @(posedge clock) begin
    out_pc    <= out_pc_d;
    out_inst  <= out_inst_d;
    pend_pc_q <= pend_pc_d;
  end

  assign out_valid = out_valid_q & ~flush;

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

  // **************************************************
  // RV32I major opcodes seen by the predictor
  // **************************************************

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // B-type layout, immediate bits scattered around rs1/rs2
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fields_t;

  // J-type layout used by jal
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fields_t;

  // one fetched word, decoded as a branch or as a jump
  typedef union packed {
    logic [31:0] raw;
    b_fields_t   b_fields;
    j_fields_t   j_fields;
  } inst_word_u;

endpackage

//--- hw/mem_pkg.sv
`include "fetch_cfg.svh"

package mem_pkg;

  // address split of a fetch PC: tag, line index, word offset, byte
  localparam int WORD_OFF_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int LINE_IDX_W = $clog2(`ICACHE_LINES);
  localparam int TAG_W      = 32 - LINE_IDX_W - WORD_OFF_W - 2;
  localparam int CREDIT_W   = $clog2(`MEM_CREDITS + 1);

  // byte address of a word, low two bits stay zero
  typedef logic [31:0] word_addr_t;

  typedef logic [LINE_IDX_W-1:0] line_index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;

  // counts words of one line, so it reaches ICACHE_LINE_WORDS itself
  typedef logic [WORD_OFF_W:0] fill_cnt_t;

  // holds 0 .. MEM_CREDITS
  typedef logic [CREDIT_W-1:0] credit_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fetch_frontend_tb \
  -f fetch_frontend.f -o fetch_frontend_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/fetch_frontend_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if echo "$sim_out" | grep -q "TB PASSED"; then
  exit 0
fi
exit 1

//--- verification/fetch_frontend_sva.sv
`include "fetch_cfg.svh"

module fetch_frontend_sva (
  input logic                clock,
  input logic                reset,
  input logic                jump_flush,
  input logic                cs_flush,
  input logic                mem_req_valid,
  input logic                mem_credit,
  input logic                out_ready,
  input logic                out_valid,
  input mem_pkg::word_addr_t out_pc,
  input logic [31:0]         out_inst
);
  timeunit 1ns;
  timeprecision 100ps;

  mem_pkg::credit_t in_use;

  // reads in flight as seen on the ports, each credit pulse closes one
  always_ff @(posedge clock) begin
    if (reset) begin
      in_use <= '0;
    end else begin
      in_use <= in_use + mem_pkg::credit_t'(mem_req_valid) - mem_pkg::credit_t'(mem_credit);
    end
  end

  held_output_stable: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_pc) && $stable(out_inst))
    else $error("downstream pc or word changed while stalled");

  request_needs_credit: assert property (@(posedge clock) disable iff (reset)
    !(mem_req_valid && in_use == mem_pkg::credit_t'(`MEM_CREDITS)))
    else $error("memory request issued with all credits in use");

  no_valid_on_flush: assert property (@(posedge clock) disable iff (reset)
    (jump_flush || cs_flush) |-> !out_valid)
    else $error("out_valid high in a flush cycle");

endmodule

bind fetch_frontend fetch_frontend_sva u_sva (.*);

//--- verification/fetch_frontend_tb.sv
`include "fetch_cfg.svh"

module fetch_frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IMG_WORDS  = 16;
  localparam int EV_BASE    = IMG_WORDS;
  localparam int GAP_LIMIT  = 200;
  localparam int LINE_BYTES = `ICACHE_LINE_WORDS * 4;

  logic                clock;
  logic                reset;
  logic                fencei;
  logic                jump_flush;
  mem_pkg::word_addr_t jump_dnpc;
  logic                cs_flush;
  mem_pkg::word_addr_t cs_dnpc;
  logic                mem_req_valid;
  mem_pkg::word_addr_t mem_req_addr;
  logic                mem_credit;
  logic                mem_resp_valid;
  logic [31:0]         mem_resp_data;
  logic                out_ready;
  logic                out_valid;
  mem_pkg::word_addr_t out_pc;
  logic [31:0]         out_inst;

  logic [31:0]         pat [64];
  logic [31:0]         lfsr;
  mem_pkg::word_addr_t resp_addr_q [$];
  int                  resp_due_q [$];
  int                  credit_due_q [$];
  int                  req_at [256];
  mem_pkg::word_addr_t expect_pc;
  int                  cycle, xfer_cnt, req_cnt, in_flight, ev_idx, gap, fence_at;
  int                  value_errs, rule_errs, timeouts;
  logic                flush_now, done;

  fetch_frontend dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // image words come from the pattern file and OP-IMM fill words cover everything else
  function automatic logic [31:0] mem_word(mem_pkg::word_addr_t addr);
    logic [31:0] offs;
    offs = addr - `FETCH_RESET_PC;
    if (offs < IMG_WORDS * 4) begin
      return pat[int'(offs >> 2)];
    end
    return {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  // jal and a branch with negative offset are taken and the rest falls through
  function automatic mem_pkg::word_addr_t predict_next(mem_pkg::word_addr_t pc, logic [31:0] w);
    logic [31:0] off;
    off = 32'd4;
    if (w[6:0] == 7'h6f) begin
      off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end else if (w[6:0] == 7'h63 && w[31]) begin
      off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end
    return pc + off;
  endfunction

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got == exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic require_true(logic ok, string what);
    assert (ok) else begin
      $display("error: %s at transfer %0d", what, xfer_cnt);
      rule_errs++;
    end
  endtask

  // **************************************************
  // memory model, consumer and redirect events
  // **************************************************

  task automatic drive_inputs();
    int         ev;
    logic [2:0] kind;
    ev   = EV_BASE + 3 * ev_idx;
    kind = pat[ev + 1][2:0];
    {fencei, jump_flush, cs_flush, mem_resp_valid, mem_credit, flush_now} = '0;
    if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
      void'(credit_due_q.pop_front());
      mem_credit = 1'b1;
    end
    if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle) begin
      void'(resp_due_q.pop_front());
      mem_resp_valid = 1'b1;
      mem_resp_data  = mem_word(resp_addr_q.pop_front());
      credit_due_q.push_back(cycle + 1);
    end
    out_ready = rand_bit() | rand_bit();
    if (kind == 3'd0) begin
      done = xfer_cnt >= int'(pat[ev]);
    end else if (xfer_cnt == int'(pat[ev])) begin
      fencei     = kind[2];
      cs_flush   = kind[1];
      jump_flush = kind[0];
      cs_dnpc    = pat[ev + 2];
      // on a combined pulse the jump target is a decoy that has to lose
      jump_dnpc  = kind[1] ? pat[ev + 2] + 32'h40 : pat[ev + 2];
      if (kind[1:0] != 2'b00) begin
        expect_pc = pat[ev + 2];
        flush_now = 1'b1;
      end
      if (kind[2]) begin
        fence_at = xfer_cnt;
      end
      ev_idx++;
    end
  endtask

  task automatic sample_outputs();
    int delay;
    if (flush_now) begin
      require_true(!out_valid, "out_valid high in a flush cycle");
    end
    // a credit pulse in this cycle only frees a read for the next one
    if (mem_req_valid) begin
      require_true(in_flight < `MEM_CREDITS, "memory request issued with no credit left");
      require_true(mem_req_addr / LINE_BYTES == dut.fetch_pc / LINE_BYTES,
                   "memory request outside the line of the missing fetch pc");
      delay = 1 + int'({rand_bit(), rand_bit()});
      resp_addr_q.push_back(mem_req_addr);
      resp_due_q.push_back(cycle + delay);
      in_flight++;
      req_cnt++;
    end
    if (mem_credit) begin
      in_flight--;
    end
    if (out_valid && out_ready) begin
      compare_value("out_pc", out_pc, expect_pc);
      compare_value("out_inst", out_inst, mem_word(expect_pc));
      expect_pc = predict_next(expect_pc, mem_word(expect_pc));
      xfer_cnt++;
      req_at[xfer_cnt] = req_cnt;
      gap = 0;
    end else begin
      gap++;
    end
  endtask

  initial begin
    lfsr = 32'h3bd8f882;
    {cycle, xfer_cnt, req_cnt, in_flight, ev_idx, gap} = '0;
    {value_errs, rule_errs, timeouts} = '0;
    fence_at  = -1;
    done      = 1'b0;
    expect_pc = `FETCH_RESET_PC;
    {fencei, jump_flush, cs_flush, mem_credit, mem_resp_valid, out_ready} = '0;
    jump_dnpc     = '0;
    cs_dnpc       = '0;
    mem_resp_data = '0;
    $readmemh("verification/fetch_patterns.hex", pat);
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    while (!done && gap < GAP_LIMIT) begin
      @(posedge clock);
      #1;
      cycle++;
      drive_inputs();
      @(negedge clock);
      sample_outputs();
    end
    if (gap >= GAP_LIMIT) begin
      $display("timeout: no transfer for %0d cycles after %0d transfers", GAP_LIMIT, xfer_cnt);
      timeouts++;
    end else if (fence_at >= 4 && fence_at + 6 <= xfer_cnt) begin
      require_true(req_at[fence_at - 4] == req_at[fence_at], "memory reads in a cached loop");
      require_true(req_at[fence_at + 6] > req_at[fence_at], "no refill after fence.i");
    end
    $display("errors: %0d value, %0d rule, %0d timeout, %0d transfers, %0d memory reads",
             value_errs, rule_errs, timeouts, xfer_cnt, req_cnt);
    if (value_errs + rule_errs + timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verification/fetch_patterns.hex
// image words from 80000000, one per line, then redirect events in hex:
// transfer count, kind (bit0 jump, bit1 cs, bit2 fence.i, 0 ends the run), target pc
00000093  // addi x1, x0, 0
00000013  // nop
00108093  // loop1: addi x1, x1, 1
00000463  // beq x0, x0, +8 is forward, so it falls through
00000013
fe209ae3  // bne x1, x2, -12 back to loop1
00000013
00000013
0100006f  // jal x0, +16 to loop2
00000013
00000013
00000013
00000013  // loop2
00108093
fe000ce3  // beq x0, x0, -8 back to loop2
00000013
// redirect events
0000000e 00000001 80000020
00000018 00000004 00000000
00000022 00000002 80000100
00000032 00000003 80000008
0000003e 00000001 80000030
00000046 00000003 80000000
00000054 00000000 00000000
